// File: dmem_sys.f
design/dmem_pkg.sv
design/block_lanes.sv
design/dcache_lookup.sv
design/mshr.sv
design/dmem_stage.sv
verif/dmem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the data memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module dmem_tb -f dmem_sys.f -o dmem_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/dmem_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// File: verif/dmem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dmem_tb;
    import dmem_pkg::*;

    localparam int NUM_SETS        = 32;
    localparam int SET_W           = $clog2(NUM_SETS);
    localparam int MEM_BYTES       = 512;
    localparam int NUM_ACCESSES    = 2000;
    localparam int RESET_CYCLES    = 16;
    localparam int CLK_PERIOD      = 10;
    localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 20 + RESET_CYCLES;

    logic       clock;
    logic       reset;
    dmem_req_t  req;
    logic       stall;
    dmem_resp_t resp;
    MEM_COMMAND proc2mem_command;
    ADDR        proc2mem_addr;
    MEM_BLOCK   proc2mem_data;
    MEM_TAG     mem2proc_transaction_tag;
    MEM_TAG     mem2proc_data_tag;
    MEM_BLOCK   mem2proc_data;

    // Memory contents, reference bytes and cache tag mirror written by the monitor
    logic [7:0]          mem_bytes [MEM_BYTES];
    logic [7:0]          ref_bytes [MEM_BYTES];
    logic [NUM_SETS-1:0] mirror_valid;
    int                  mirror_block [NUM_SETS];
    DATA                 expected_loads [$];
    int                  cycle;
    int                  accept_count;
    logic                outstanding;
    MEM_TAG              out_tag;
    MEM_TAG              next_tag;
    int                  ret_addr;
    int                  ret_cycle;
    int                  hit_resp_cycle;
    int                  hits;
    int                  misses;
    int                  refusals;

    dmem_stage #(
        .NUM_SETS (NUM_SETS)
    ) u_dmem_stage (
        .clock                    (clock),
        .reset                    (reset),
        .req                      (req),
        .stall                    (stall),
        .resp                     (resp),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data)
    );

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    function automatic logic [7:0] pattern_byte(input int a);
        return 8'((a * 29) ^ (a >> 5) ^ 32'h5a);
    endfunction

    function automatic int size_bytes(input MEM_SIZE size);
        case (size)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    // Little endian and zero extended with wrap inside the 8-byte block
    function automatic DATA expected_load(input ADDR addr, input MEM_SIZE size);
        DATA d;
        int  base;
        int  ofs;

        d    = '0;
        base = int'(addr) & ~7;
        ofs  = int'(addr) & 7;
        for (int i = 0; i < size_bytes(size); i++) begin
            d[8*i +: 8] = ref_bytes[9'(base + ((ofs + i) % 8))];
        end
        return d;
    endfunction

    task automatic apply_store(input ADDR addr, input MEM_SIZE size, input DATA data);
        int base;
        int ofs;

        base = int'(addr) & ~7;
        ofs  = int'(addr) & 7;
        for (int i = 0; i < size_bytes(size); i++) begin
            ref_bytes[9'(base + ((ofs + i) % 8))] = data[8*i +: 8];
        end
    endtask

    function automatic MEM_BLOCK ref_block(input int base);
        MEM_BLOCK b;

        for (int j = 0; j < 8; j++) begin
            b[8*j +: 8] = ref_bytes[9'(base + j)];
        end
        return b;
    endfunction

    function automatic MEM_BLOCK mem_block(input int base);
        MEM_BLOCK b;

        for (int j = 0; j < 8; j++) begin
            b[8*j +: 8] = mem_bytes[9'(base + j)];
        end
        return b;
    endfunction

    task automatic write_mem_block(input int base, input MEM_BLOCK b);
        for (int j = 0; j < 8; j++) begin
            mem_bytes[9'(base + j)] = b[8*j +: 8];
        end
    endtask

    task automatic drive_random_request();
        dmem_req_t r;

        r.valid    = 1'b1;
        r.addr     = ADDR'($urandom % MEM_BYTES);
        r.data     = $urandom;
        r.is_store = ($urandom % 100) >= 60;
        case ($urandom % 3)
            0:       r.size = BYTE;
            1:       r.size = HALF;
            default: r.size = WORD;
        endcase
        req = r;
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation hang");
    end

    // Memory side with tag offers, refusals and delayed data return
    initial begin : memory_model
        mem2proc_transaction_tag = '0;
        mem2proc_data_tag        = '0;
        mem2proc_data            = '0;
        forever begin
            @(negedge clock);
            // About one load in eight is refused with tag zero
            mem2proc_transaction_tag = (reset || $urandom % 8 == 0) ? MEM_TAG'(0) : next_tag;
            if (!reset && outstanding && cycle == ret_cycle) begin
                mem2proc_data_tag = out_tag;
                mem2proc_data     = mem_block(ret_addr);
            end else begin
                mem2proc_data_tag = '0;
                mem2proc_data     = '0;
            end
        end
    end

    initial begin : monitor
        logic             accepted;
        logic             mirror_hit;
        int               blk;
        logic [SET_W-1:0] set_idx;

        for (int a = 0; a < MEM_BYTES; a++) begin
            mem_bytes[9'(a)] = pattern_byte(a);
            ref_bytes[9'(a)] = pattern_byte(a);
        end
        mirror_valid   = '0;
        cycle          = 0;
        accept_count   = 0;
        outstanding    = 1'b0;
        out_tag        = '0;
        next_tag       = 4'd1;
        ret_addr       = 0;
        ret_cycle      = -1;
        hit_resp_cycle = -1;
        hits           = 0;
        misses         = 0;
        refusals       = 0;
        forever begin
            @(posedge clock);
            if (!reset) begin
                accepted   = req.valid && !stall;
                blk        = int'(req.addr) >> BLOCK_OFS_W;
                set_idx    = SET_W'(blk % NUM_SETS);
                mirror_hit = mirror_valid[set_idx] && (mirror_block[set_idx] == blk);

                if (cycle == hit_resp_cycle) begin
                    check_value(64'(resp.valid), 64'd1, "load hit response one cycle later");
                end
                if (resp.valid) begin
                    check_value(64'(expected_loads.size() != 0), 64'd1, "response without a load");
                    check_value(64'(resp.data), 64'(expected_loads.pop_front()), "load data");
                end

                if (outstanding) begin
                    check_value(64'(stall), 64'd1, "stall while a miss is outstanding");
                end
                if (mem2proc_data_tag != '0) begin
                    outstanding = 1'b0;
                end

                if (accepted) begin
                    if (mirror_hit) begin
                        hits++;
                        check_value(64'(proc2mem_command),
                                    64'(req.is_store ? MEM_STORE : MEM_NONE), "command on a hit");
                    end else begin
                        misses++;
                        check_value(64'(proc2mem_command), 64'(MEM_LOAD), "command on a miss");
                        mirror_valid[set_idx] = 1'b1;
                        mirror_block[set_idx] = blk;
                    end
                    if (req.is_store) begin
                        apply_store(req.addr, req.size, req.data);
                    end else begin
                        expected_loads.push_back(expected_load(req.addr, req.size));
                        if (mirror_hit) begin
                            hit_resp_cycle = cycle + 1;
                        end
                    end
                    accept_count++;
                end

                case (proc2mem_command)
                    MEM_LOAD: begin
                        check_value(64'(mirror_hit), 64'd0, "memory load for a resident block");
                        check_value(64'(outstanding), 64'd0, "second memory load during a miss");
                        check_value(64'(proc2mem_addr), 64'({req.addr[ADDR_W-1:3], 3'b000}),
                                    "memory load address");
                        if (mem2proc_transaction_tag != '0) begin
                            outstanding = 1'b1;
                            out_tag     = mem2proc_transaction_tag;
                            ret_addr    = int'(proc2mem_addr);
                            ret_cycle   = cycle + 1 + int'($urandom % 6);
                            next_tag    = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                        end else begin
                            refusals++;
                            check_value(64'(stall), 64'd1, "stall on a refused memory load");
                        end
                    end
                    MEM_STORE: begin
                        check_value(64'(proc2mem_addr[2:0]), 64'd0, "store block alignment");
                        check_value(64'(int'(proc2mem_addr) < MEM_BYTES), 64'd1, "store range");
                        check_value(64'(proc2mem_data), 64'(ref_block(int'(proc2mem_addr))),
                                    "write-through block");
                        write_mem_block(int'(proc2mem_addr), proc2mem_data);
                    end
                    default: begin
                    end
                endcase
                cycle++;
            end
        end
    end

    initial begin
        int seed_value;

        seed_value = $urandom(32'h12b9);
        reset      = 1'b1;
        req        = '0;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clock);
            if (c > 0) begin
                check_value(64'(proc2mem_command), 64'(MEM_NONE), "command during reset");
                check_value(64'(stall), 64'd0, "stall during reset");
                check_value(64'(resp.valid), 64'd0, "response during reset");
            end
        end
        @(negedge clock);
        reset = 1'b0;
        @(posedge clock);
        check_value(64'(proc2mem_command), 64'(MEM_NONE), "command after reset");
        check_value(64'(stall), 64'd0, "stall after reset");
        check_value(64'(resp.valid), 64'd0, "response after reset");

        @(negedge clock);
        for (int k = 0; k < NUM_ACCESSES; k++) begin
            if ($urandom % 4 == 0) begin
                req.valid = 1'b0;
                @(negedge clock);
            end
            drive_random_request();
            // Held until accepted even through refusals and misses
            @(negedge clock);
            while (accept_count == k) begin
                @(negedge clock);
            end
        end
        req.valid = 1'b0;
        while (outstanding || stall) begin
            @(negedge clock);
        end
        repeat (4) @(negedge clock);

        check_value(64'(expected_loads.size()), 64'd0, "unanswered loads");
        check_value(64'(hits > 0), 64'd1, "cache hits seen");
        check_value(64'(misses > 0), 64'd1, "cache misses seen");
        check_value(64'(refusals > 0), 64'd1, "memory refusals seen");
        $display("Accesses %0d, hits %0d, misses %0d, refusals %0d",
                 accept_count, hits, misses, refusals);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/dmem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module dmem_stage #(
    parameter int NUM_SETS = 32
) (
    input  logic                   clock,
    input  logic                   reset,

    input  dmem_pkg::dmem_req_t    req,
    output logic                   stall,
    output dmem_pkg::dmem_resp_t   resp,

    output dmem_pkg::MEM_COMMAND   proc2mem_command,
    output dmem_pkg::ADDR          proc2mem_addr,
    output dmem_pkg::MEM_BLOCK     proc2mem_data,
    input  dmem_pkg::MEM_TAG       mem2proc_transaction_tag,
    input  dmem_pkg::MEM_TAG       mem2proc_data_tag,
    input  dmem_pkg::MEM_BLOCK     mem2proc_data
);
    import dmem_pkg::*;

    logic     hit;
    MEM_BLOCK hit_store_block;
    fill_t    fill;

    dcache_lookup #(
        .NUM_SETS (NUM_SETS)
    ) u_dcache_lookup (
        .clock           (clock),
        .reset           (reset),
        .req             (req),
        .fill            (fill),
        .stall           (stall),
        .hit             (hit),
        .hit_store_block (hit_store_block),
        .resp            (resp)
    );

    mshr u_mshr (
        .clock                    (clock),
        .reset                    (reset),
        .req                      (req),
        .hit                      (hit),
        .hit_store_block          (hit_store_block),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .fill                     (fill),
        .stall                    (stall)
    );

endmodule

`default_nettype wire

// File: design/mshr.sv
`timescale 1ns/1ns
`default_nettype none

module mshr (
    input  logic                   clock,
    input  logic                   reset,
    input  dmem_pkg::dmem_req_t    req,
    input  logic                   hit,
    input  dmem_pkg::MEM_BLOCK     hit_store_block,
    input  dmem_pkg::MEM_TAG       mem2proc_transaction_tag,
    input  dmem_pkg::MEM_TAG       mem2proc_data_tag,
    input  dmem_pkg::MEM_BLOCK     mem2proc_data,
    output dmem_pkg::MEM_COMMAND   proc2mem_command,
    output dmem_pkg::ADDR          proc2mem_addr,
    output dmem_pkg::MEM_BLOCK     proc2mem_data,
    output dmem_pkg::fill_t        fill,
    output logic                   stall
);
    import dmem_pkg::*;

    mshr_entry_t entry;
    mshr_entry_t next_entry;
    MEM_BLOCK    merged_block;
    MEM_BLOCK    fill_block;
    ADDR         req_block_addr;
    ADDR         entry_block_addr;

    assign req_block_addr   = {req.addr[ADDR_W-1:BLOCK_OFS_W], {BLOCK_OFS_W{1'b0}}};
    assign entry_block_addr = {entry.addr[ADDR_W-1:BLOCK_OFS_W], {BLOCK_OFS_W{1'b0}}};

    // Store miss data lands in the returned block
    block_lanes u_store_merge (
        .block      (entry.mem_data),
        .offset     (entry.addr[BLOCK_OFS_W-1:0]),
        .size       (entry.size),
        .store_data (entry.data),
        .merged     (merged_block),
        .load_data  ()
    );

    assign fill_block = entry.is_store ? merged_block : entry.mem_data;

    always_comb begin
        next_entry       = entry;
        proc2mem_command = MEM_NONE;
        proc2mem_addr    = '0;
        proc2mem_data    = '0;
        stall            = (entry.state != NONE);

        case (entry.state)
            NONE: begin
                if (req.valid && hit && req.is_store) begin
                    proc2mem_command = MEM_STORE;
                    proc2mem_addr    = req_block_addr;
                    proc2mem_data    = hit_store_block;
                end else if (req.valid && !hit) begin
                    proc2mem_command = MEM_LOAD;
                    proc2mem_addr    = req_block_addr;
                    if (mem2proc_transaction_tag != '0) begin
                        next_entry.state    = WAITING_FOR_LOAD_DATA;
                        next_entry.addr     = req.addr;
                        next_entry.data     = req.data;
                        next_entry.size     = req.size;
                        next_entry.is_store = req.is_store;
                        next_entry.mem_tag  = mem2proc_transaction_tag;
                    end else begin
                        // Refused, requester holds and retries
                        stall = 1'b1;
                    end
                end
            end
            WAITING_FOR_LOAD_DATA: begin
                if (mem2proc_data_tag != '0 && mem2proc_data_tag == entry.mem_tag) begin
                    next_entry.state    = TRANSACTION_COMPLETE;
                    next_entry.mem_data = mem2proc_data;
                end
            end
            TRANSACTION_COMPLETE: begin
                next_entry = '0;
                if (entry.is_store) begin
                    proc2mem_command = MEM_STORE;
                    proc2mem_addr    = entry_block_addr;
                    proc2mem_data    = merged_block;
                end
            end
            default: begin
                next_entry = '0;
            end
        endcase
    end

    always_comb begin
        fill.wr       = (entry.state == TRANSACTION_COMPLETE);
        fill.addr     = entry.addr;
        fill.block    = fill_block;
        fill.size     = entry.size;
        fill.is_store = entry.is_store;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry <= '0;
        end else begin
            entry <= next_entry;
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_lookup #(
    parameter int NUM_SETS = 32
) (
    input  logic                 clock,
    input  logic                 reset,
    input  dmem_pkg::dmem_req_t  req,
    input  dmem_pkg::fill_t      fill,
    input  logic                 stall,
    output logic                 hit,
    output dmem_pkg::MEM_BLOCK   hit_store_block,
    output dmem_pkg::dmem_resp_t resp
);
    import dmem_pkg::*;

    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W   = ADDR_W - BLOCK_OFS_W - INDEX_W;

    logic [NUM_SETS-1:0] valid_bits;
    logic [TAG_W-1:0]    tags [NUM_SETS];
    MEM_BLOCK            blocks [NUM_SETS];

    logic [INDEX_W-1:0] req_index;
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;
    MEM_BLOCK           req_block;
    DATA                hit_load_data;
    DATA                fill_load_data;
    logic               accept_hit;
    logic               store_hit_wr;
    logic               resp_valid;
    DATA                resp_data;

    assign req_index  = req.addr[BLOCK_OFS_W +: INDEX_W];
    assign req_tag    = req.addr[ADDR_W-1 -: TAG_W];
    assign fill_index = fill.addr[BLOCK_OFS_W +: INDEX_W];
    assign fill_tag   = fill.addr[ADDR_W-1 -: TAG_W];

    assign req_block = blocks[req_index];

    assign hit = req.valid && valid_bits[req_index] && (tags[req_index] == req_tag);

    // While the MSHR is busy the held request is not yet accepted
    assign accept_hit   = hit && !stall;
    assign store_hit_wr = accept_hit && req.is_store;

    block_lanes u_req_lanes (
        .block      (req_block),
        .offset     (req.addr[BLOCK_OFS_W-1:0]),
        .size       (req.size),
        .store_data (req.data),
        .merged     (hit_store_block),
        .load_data  (hit_load_data)
    );

    // Load answer of a completed miss, taken from the fill block
    block_lanes u_fill_lanes (
        .block      (fill.block),
        .offset     (fill.addr[BLOCK_OFS_W-1:0]),
        .size       (fill.size),
        .store_data ('0),
        .merged     (),
        .load_data  (fill_load_data)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill.wr) begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill.wr) begin
            tags[fill_index]   <= fill_tag;
            blocks[fill_index] <= fill.block;
        end else if (store_hit_wr) begin
            blocks[req_index] <= hit_store_block;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= (accept_hit && !req.is_store) || (fill.wr && !fill.is_store);
        end
    end

    // Fill and an accepted hit never share a cycle
    always_ff @(posedge clock) begin
        if (fill.wr) begin
            resp_data <= fill_load_data;
        end else begin
            resp_data <= hit_load_data;
        end
    end

    assign resp = '{valid: resp_valid, data: resp_data};

endmodule

`default_nettype wire

// File: design/block_lanes.sv
`timescale 1ns/1ns
`default_nettype none

module block_lanes (
    input  dmem_pkg::MEM_BLOCK                 block,
    input  logic [dmem_pkg::BLOCK_OFS_W-1:0]   offset,
    input  dmem_pkg::MEM_SIZE                  size,
    input  dmem_pkg::DATA                      store_data,
    output dmem_pkg::MEM_BLOCK                 merged,
    output dmem_pkg::DATA                      load_data
);
    import dmem_pkg::*;

    localparam int WORD_BYTES = DATA_W / 8;

    logic [2:0] n_bytes;

    always_comb begin
        case (size)
            BYTE:    n_bytes = 3'd1;
            HALF:    n_bytes = 3'd2;
            default: n_bytes = 3'd4;
        endcase
    end

    // Byte i of the word maps to lane offset+i, wrapping inside the block
    always_comb begin
        logic [BLOCK_OFS_W-1:0] lane;

        merged    = block;
        load_data = '0;
        for (int i = 0; i < WORD_BYTES; i++) begin
            lane = offset + BLOCK_OFS_W'(i);
            if (i < int'(n_bytes)) begin
                merged[8*lane +: 8]  = store_data[8*i +: 8];
                load_data[8*i +: 8]  = block[8*lane +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

    localparam int ADDR_W      = 16;
    localparam int DATA_W      = 32;
    localparam int BLOCK_W     = 64;
    localparam int BLOCK_OFS_W = 3;
    localparam int TAG_BITS    = 4;

    typedef logic [ADDR_W-1:0]   ADDR;
    typedef logic [DATA_W-1:0]   DATA;
    typedef logic [BLOCK_W-1:0]  MEM_BLOCK;
    // Zero means no transaction
    typedef logic [TAG_BITS-1:0] MEM_TAG;

    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } MEM_SIZE;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } MEM_COMMAND;

    typedef enum logic [1:0] {
        NONE                  = 2'h0,
        WAITING_FOR_LOAD_DATA = 2'h1,
        TRANSACTION_COMPLETE  = 2'h2
    } MSHR_STATE;

    typedef struct packed {
        logic    valid;
        ADDR     addr;
        DATA     data;
        MEM_SIZE size;
        logic    is_store;
    } dmem_req_t;

    typedef struct packed {
        logic valid;
        DATA  data;
    } dmem_resp_t;

    typedef struct packed {
        MSHR_STATE state;
        ADDR       addr;
        DATA       data;
        MEM_SIZE   size;
        logic      is_store;
        MEM_TAG    mem_tag;
        MEM_BLOCK  mem_data;
    } mshr_entry_t;

    // Block is already merged when the miss was a store
    typedef struct packed {
        logic     wr;
        ADDR      addr;
        MEM_BLOCK block;
        MEM_SIZE  size;
        logic     is_store;
    } fill_t;

endpackage

`default_nettype wire
